/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tbIntExec
FILELIST = compile.f
OBJDIR   = obj_dir
LOG      = sim.log
SOURCES  = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: compile
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* branchPkg.sv */
package branchPkg;

    localparam int SQN_BITS = 7;  // sequence number width, execPkg::SqN is built on it

    typedef logic [31:0] CodeAddr;

    // why the front end has to refetch
    typedef enum logic [1:0] {
        FLUSH_BRANCH_TK,
        FLUSH_BRANCH_NT,
        FLUSH_IBRANCH
    } FlushCause;

    typedef enum logic [1:0] {
        FLAGS_NONE,
        FLAGS_BRANCH,
        FLAGS_MISPRED
    } ResFlags;

    typedef struct packed {
        logic valid;
        logic [SQN_BITS-1:0] sqN;
        CodeAddr dstPC;
        FlushCause cause;
    } BranchRedirect;

endpackage

/* branchResolver.sv */
`timescale 1ns/1ps

module branchResolver (
    input execPkg::ExUop headUop,
    output branchPkg::BranchRedirect redirectComb,
    output branchPkg::ResFlags flagsComb
);
    import execPkg::*;
    import branchPkg::*;

    CodeAddr takenTarget;
    CodeAddr fallThrough;
    CodeAddr jumpTarget;
    logic isCondBranch;
    logic taken;
    logic jumpMiss;
    logic lessThan;
    logic lessThanU;

    assign lessThan = $signed(headUop.srcA) < $signed(headUop.srcB);
    assign lessThanU = headUop.srcA < headUop.srcB;

    assign takenTarget = headUop.pc + {{19{headUop.imm[12]}}, headUop.imm[12:0]};
    assign fallThrough = headUop.pc + (headUop.compressed ? 32'd2 : 32'd4);
    assign jumpTarget = (headUop.srcA + {{20{headUop.imm[11]}}, headUop.imm[11:0]})
                        & ~CodeAddr'(1);

    // bit 0 of the predicted target is don't care
    assign jumpMiss = !headUop.predTaken || (jumpTarget[31:1] != headUop.predTarget[31:1]);

    always_comb begin
        isCondBranch = 1'b1;
        case (headUop.opcode)
            INT_BEQ: taken = headUop.srcA == headUop.srcB;
            INT_BNE: taken = headUop.srcA != headUop.srcB;
            INT_BLT: taken = lessThan;
            INT_BGE: taken = !lessThan;
            INT_BLTU: taken = lessThanU;
            INT_BGEU: taken = !lessThanU;
            default: begin
                taken = 1'b0;
                isCondBranch = 1'b0;
            end
        endcase
    end

    always_comb begin
        redirectComb = '0;
        redirectComb.sqN = headUop.sqN;
        flagsComb = FLAGS_NONE;
        if (headUop.valid) begin
            if (isCondBranch) begin
                flagsComb = FLAGS_BRANCH;
                if (taken != headUop.predTaken) begin
                    redirectComb.valid = 1'b1;
                    redirectComb.dstPC = taken ? takenTarget : fallThrough;
                    redirectComb.cause = taken ? FLUSH_BRANCH_TK : FLUSH_BRANCH_NT;
                    flagsComb = FLAGS_MISPRED;
                end
            end else if (headUop.opcode == INT_JALR) begin
                flagsComb = jumpMiss ? FLAGS_MISPRED : FLAGS_BRANCH;
                redirectComb.valid = jumpMiss;
                redirectComb.dstPC = jumpTarget;
                redirectComb.cause = FLUSH_IBRANCH;
            end else if (headUop.opcode == INT_JAL) begin
                flagsComb = FLAGS_BRANCH;   // target already taken by fetch
            end
        end
    end

endmodule

/* compile.f */
branchPkg.sv
execPkg.sv
uopBuffer.sv
intAlu.sv
branchResolver.sv
execWriteback.sv
intExecUnit.sv
tbIntExec.sv

/* execPkg.sv */
package execPkg;

    typedef logic [31:0] DataWord;
    typedef logic [branchPkg::SQN_BITS-1:0] SqN;  // wraps, ordered by signed difference
    typedef logic [5:0] Tag;

    typedef enum logic [5:0] {
        INT_ADD,
        INT_SUB,
        INT_XOR,
        INT_OR,
        INT_AND,
        INT_SLL,
        INT_SRL,
        INT_SRA,
        INT_SLT,
        INT_SLTU,
        INT_LUI,
        INT_AUIPC,
        INT_SH1ADD,
        INT_SH2ADD,
        INT_SH3ADD,
        INT_ANDN,
        INT_ORN,
        INT_XNOR,
        INT_MIN,
        INT_MAX,
        INT_MINU,
        INT_MAXU,
        INT_CLZ,
        INT_CTZ,
        INT_CPOP,
        INT_REV8,
        INT_ORC_B,
        INT_SE_B,
        INT_SE_H,
        INT_ZE_H,
        INT_JAL,
        INT_JALR,
        INT_BEQ,
        INT_BNE,
        INT_BLT,
        INT_BGE,
        INT_BLTU,
        INT_BGEU
    } IntOpcode;

    typedef struct packed {
        logic valid;
        IntOpcode opcode;
        DataWord srcA;
        DataWord srcB;
        DataWord imm;
        branchPkg::CodeAddr pc;
        logic compressed;          // 16-bit encoding, next pc is pc+2
        Tag tagDst;
        SqN sqN;
        logic predTaken;
        branchPkg::CodeAddr predTarget;
    } ExUop;

    typedef struct packed {
        logic valid;
        DataWord result;
        Tag tagDst;
        SqN sqN;
        branchPkg::ResFlags flags;
    } ResUop;

endpackage

/* execWriteback.sv */
`timescale 1ns/1ps

module execWriteback #(
    parameter int RES_CREDITS = 2
) (
    input logic clk,
    input logic rst,
    input execPkg::ExUop headUop,
    input execPkg::DataWord aluResult,
    input branchPkg::BranchRedirect redirectComb,
    input branchPkg::ResFlags flagsComb,
    input logic invalidate,
    input execPkg::SqN invalidateSqN,
    input logic resCredit,
    output logic pop,
    output execPkg::ResUop resUop,
    output branchPkg::BranchRedirect redirect
);
    import execPkg::*;

    localparam int CREDIT_BITS = $clog2(RES_CREDITS + 1);

    typedef logic [CREDIT_BITS-1:0] CreditCount;

    CreditCount credits;
    SqN sqDiff;
    logic squash;
    logic haveCredit;
    logic emit;

    assign sqDiff = headUop.sqN - invalidateSqN;
    assign squash = invalidate && ($signed(sqDiff) > 0);  // younger than the flush point
    assign haveCredit = (credits != '0);
    assign emit = headUop.valid && !squash && haveCredit;
    assign pop = headUop.valid && (squash || haveCredit);  // squashed head drains for free

    always_ff @(posedge clk) begin
        if (emit) begin
            resUop.result <= aluResult;
            resUop.tagDst <= headUop.tagDst;
            resUop.sqN <= headUop.sqN;
            resUop.flags <= flagsComb;
            redirect.sqN <= redirectComb.sqN;
            redirect.dstPC <= redirectComb.dstPC;
            redirect.cause <= redirectComb.cause;
        end
        if (rst) begin
            resUop.valid <= 1'b0;
            redirect.valid <= 1'b0;
            credits <= CreditCount'(RES_CREDITS);
        end else begin
            resUop.valid <= emit;
            redirect.valid <= emit && redirectComb.valid;
            credits <= credits - CreditCount'(emit) + CreditCount'(resCredit);
        end
    end

endmodule

/* intAlu.sv */
`timescale 1ns/1ps

module intAlu (
    input execPkg::ExUop headUop,
    output execPkg::DataWord aluResult
);
    import execPkg::*;

    typedef logic [5:0] BitCount;  // 0 to 32

    function automatic BitCount leadingZeros(input DataWord value);
        BitCount n;
        logic found;
        n = '0;
        found = 1'b0;
        for (int i = 31; i >= 0; i--) begin
            if (value[i])
                found = 1'b1;
            else if (!found)
                n = n + 1'b1;
        end
        return n;
    endfunction

    function automatic BitCount popCount(input DataWord value);
        BitCount n;
        n = '0;
        for (int i = 0; i < 32; i++)
            n = n + BitCount'(value[i]);
        return n;
    endfunction

    DataWord srcA;
    DataWord srcB;
    DataWord srcARev;
    DataWord linkAddr;
    BitCount zeroCount;
    logic lessThan;
    logic lessThanU;

    assign srcA = headUop.srcA;
    assign srcB = headUop.srcB;
    assign srcARev = {<<{srcA}};
    assign lessThan = $signed(srcA) < $signed(srcB);
    assign lessThanU = srcA < srcB;
    assign linkAddr = headUop.pc + (headUop.compressed ? 32'd2 : 32'd4);

    // ctz is clz of the mirrored operand, so one counter serves both
    assign zeroCount = leadingZeros((headUop.opcode == INT_CTZ) ? srcARev : srcA);

    always_comb begin
        case (headUop.opcode)
            INT_ADD: aluResult = srcA + srcB;
            INT_SUB: aluResult = srcA - srcB;
            INT_XOR: aluResult = srcA ^ srcB;
            INT_OR: aluResult = srcA | srcB;
            INT_AND: aluResult = srcA & srcB;
            INT_SLL: aluResult = srcA << srcB[4:0];
            INT_SRL: aluResult = srcA >> srcB[4:0];
            INT_SRA: aluResult = $signed(srcA) >>> srcB[4:0];
            INT_SLT: aluResult = {31'b0, lessThan};
            INT_SLTU: aluResult = {31'b0, lessThanU};
            INT_LUI: aluResult = srcB;                 // upper immediate arrives as operand b
            INT_AUIPC: aluResult = headUop.pc + headUop.imm;
            INT_SH1ADD: aluResult = srcB + (srcA << 1);
            INT_SH2ADD: aluResult = srcB + (srcA << 2);
            INT_SH3ADD: aluResult = srcB + (srcA << 3);
            INT_ANDN: aluResult = srcA & ~srcB;
            INT_ORN: aluResult = srcA | ~srcB;
            INT_XNOR: aluResult = srcA ^ ~srcB;
            INT_MIN: aluResult = lessThan ? srcA : srcB;
            INT_MAX: aluResult = lessThan ? srcB : srcA;
            INT_MINU: aluResult = lessThanU ? srcA : srcB;
            INT_MAXU: aluResult = lessThanU ? srcB : srcA;
            INT_CLZ,
            INT_CTZ: aluResult = {26'b0, zeroCount};
            INT_CPOP: aluResult = {26'b0, popCount(srcA)};
            INT_REV8: aluResult = {srcA[7:0], srcA[15:8], srcA[23:16], srcA[31:24]};
            INT_ORC_B: aluResult = {{8{|srcA[31:24]}}, {8{|srcA[23:16]}},
                                    {8{|srcA[15:8]}}, {8{|srcA[7:0]}}};
            INT_SE_B: aluResult = {{24{srcA[7]}}, srcA[7:0]};
            INT_SE_H: aluResult = {{16{srcA[15]}}, srcA[15:0]};
            INT_ZE_H: aluResult = {16'b0, srcA[15:0]};
            INT_JAL,
            INT_JALR: aluResult = linkAddr;
            INT_BEQ, INT_BNE, INT_BLT,
            INT_BGE, INT_BLTU, INT_BGEU: aluResult = '0;  // no register result
            default: aluResult = '0;
        endcase
    end

endmodule

/* intExecUnit.sv */
`timescale 1ns/1ps

module intExecUnit #(
    parameter int BUF_DEPTH = 4,
    parameter int RES_CREDITS = 2
) (
    input logic clk,
    input logic rst,
    input execPkg::ExUop inUop,
    output logic issueCredit,
    input logic invalidate,
    input execPkg::SqN invalidateSqN,
    input logic resCredit,
    output execPkg::ResUop resUop,
    output branchPkg::BranchRedirect redirect
);
    import execPkg::*;
    import branchPkg::*;

    ExUop headUop;
    DataWord aluResult;
    BranchRedirect redirectComb;
    ResFlags flagsComb;
    logic pop;

    uopBuffer #(
        .BUF_DEPTH(BUF_DEPTH)
    ) buffer (
        .clk(clk),
        .rst(rst),
        .inUop(inUop),
        .pop(pop),
        .headUop(headUop),
        .issueCredit(issueCredit)
    );

    // alu and resolver both look at the head in the same cycle
    intAlu alu (
        .headUop(headUop),
        .aluResult(aluResult)
    );

    branchResolver resolver (
        .headUop(headUop),
        .redirectComb(redirectComb),
        .flagsComb(flagsComb)
    );

    execWriteback #(
        .RES_CREDITS(RES_CREDITS)
    ) writeback (
        .clk(clk),
        .rst(rst),
        .headUop(headUop),
        .aluResult(aluResult),
        .redirectComb(redirectComb),
        .flagsComb(flagsComb),
        .invalidate(invalidate),
        .invalidateSqN(invalidateSqN),
        .resCredit(resCredit),
        .pop(pop),
        .resUop(resUop),
        .redirect(redirect)
    );

endmodule

/* tbIntExec.sv */
`timescale 1ns/1ps

module tbIntExec;
    import execPkg::*;
    import branchPkg::*;

    localparam int BUF_DEPTH = 4;
    localparam int RES_CREDITS = 2;
    localparam int NUM_STEPS = 3000;
    localparam int TIMEOUT_CYCLES = 2000;

    typedef struct packed {
        logic squashed;
        DataWord result;
        Tag tagDst;
        SqN sqN;
        ResFlags flags;
        BranchRedirect redir;
    } Expect;

    logic clk;
    logic rst;
    ExUop inUop;
    logic issueCredit;
    logic invalidate;
    SqN invalidateSqN;
    logic resCredit;
    ResUop resUop;
    BranchRedirect redirect;

    logic [31:0] lfsr;
    Expect expected[$];
    int issuerCredits;
    int pendingReturn;  // results taken but not yet credited back
    int holdCycles;
    int issued;
    int completed;
    int squashedCount;
    int redirects;
    SqN nextSqN;

    intExecUnit #(
        .BUF_DEPTH(BUF_DEPTH),
        .RES_CREDITS(RES_CREDITS)
    ) dut (
        .clk(clk),
        .rst(rst),
        .inUop(inUop),
        .issueCredit(issueCredit),
        .invalidate(invalidate),
        .invalidateSqN(invalidateSqN),
        .resCredit(resCredit),
        .resUop(resUop),
        .redirect(redirect)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic checkEq(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp)
            abortRun($sformatf("FAILED at %0d ns: %s is %0h, expected %0h",
                               $time, what, got, exp));
    endtask

    function automatic ExUop randomUop(input SqN seq);
        ExUop u;
        DataWord jumpTarget;
        u = '0;
        u.valid = 1'b1;
        u.opcode = IntOpcode'(6'(randBits(6) % 38));
        u.srcA = randBits(32);
        if (randBits(2) == 0)
            u.srcA = u.srcA >> randBits(5);  // sparse operands for the bit counts
        u.srcB = (randBits(2) == 0) ? u.srcA : randBits(32);
        u.imm = randBits(32);
        u.pc = randBits(32);
        u.compressed = randBits(1) != 0;
        u.tagDst = Tag'(randBits(6));
        u.sqN = seq;
        u.predTaken = randBits(1) != 0;
        jumpTarget = u.srcA + {{20{u.imm[11]}}, u.imm[11:0]};
        // half the jalr predictions hit, bit 0 may be junk
        u.predTarget = (randBits(1) != 0) ? (jumpTarget ^ randBits(1)) : randBits(32);
        return u;
    endfunction

    function automatic Expect predict(input ExUop u);
        Expect e;
        DataWord a;
        DataWord b;
        DataWord r;
        DataWord link;
        DataWord target;
        int n;
        logic isBranch;
        logic taken;
        a = u.srcA;
        b = u.srcB;
        r = '0;
        n = 0;
        isBranch = u.opcode inside {INT_BEQ, INT_BNE, INT_BLT, INT_BGE, INT_BLTU, INT_BGEU};
        taken = 1'b0;
        link = u.pc + (u.compressed ? 32'd2 : 32'd4);
        case (u.opcode)
            INT_ADD: r = a + b;
            INT_SUB: r = a - b;
            INT_XOR: r = a ^ b;
            INT_OR: r = a | b;
            INT_AND: r = a & b;
            INT_SLL: r = a << b[4:0];
            INT_SRL: r = a >> b[4:0];
            INT_SRA: r = $unsigned($signed(a) >>> b[4:0]);
            INT_SLT: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            INT_SLTU: r = (a < b) ? 32'd1 : 32'd0;
            INT_LUI: r = b;
            INT_AUIPC: r = u.pc + u.imm;
            INT_SH1ADD: r = (a << 1) + b;
            INT_SH2ADD: r = (a << 2) + b;
            INT_SH3ADD: r = (a << 3) + b;
            INT_ANDN: r = a & ~b;
            INT_ORN: r = a | ~b;
            INT_XNOR: r = ~(a ^ b);
            INT_MIN: r = ($signed(a) < $signed(b)) ? a : b;
            INT_MAX: r = ($signed(a) > $signed(b)) ? a : b;
            INT_MINU: r = (a < b) ? a : b;
            INT_MAXU: r = (a > b) ? a : b;
            INT_CLZ: begin
                for (int i = 31; i >= 0; i--) begin
                    if (a[i])
                        break;
                    n++;
                end
                r = DataWord'(n);
            end
            INT_CTZ: begin
                for (int i = 0; i < 32; i++) begin
                    if (a[i])
                        break;
                    n++;
                end
                r = DataWord'(n);
            end
            INT_CPOP: begin
                for (int i = 0; i < 32; i++)
                    n += int'(a[i]);
                r = DataWord'(n);
            end
            INT_REV8: begin
                for (int i = 0; i < 4; i++)
                    r[8*i +: 8] = a[8*(3-i) +: 8];
            end
            INT_ORC_B: begin
                for (int i = 0; i < 4; i++)
                    r[8*i +: 8] = (a[8*i +: 8] != 8'h00) ? 8'hff : 8'h00;
            end
            INT_SE_B: r = {{24{a[7]}}, a[7:0]};
            INT_SE_H: r = {{16{a[15]}}, a[15:0]};
            INT_ZE_H: r = {16'h0000, a[15:0]};
            INT_JAL, INT_JALR: r = link;
            INT_BEQ: taken = (a == b);
            INT_BNE: taken = (a != b);
            INT_BLT: taken = $signed(a) < $signed(b);
            INT_BGE: taken = $signed(a) >= $signed(b);
            INT_BLTU: taken = a < b;
            INT_BGEU: taken = a >= b;
            default: r = '0;
        endcase
        e = '0;
        e.result = r;
        e.tagDst = u.tagDst;
        e.sqN = u.sqN;
        e.flags = FLAGS_NONE;
        e.redir.sqN = u.sqN;
        if (isBranch) begin
            e.flags = FLAGS_BRANCH;
            if (taken != u.predTaken) begin
                e.flags = FLAGS_MISPRED;
                e.redir.valid = 1'b1;
                e.redir.dstPC = taken ? u.pc + {{19{u.imm[12]}}, u.imm[12:0]} : link;
                e.redir.cause = taken ? FLUSH_BRANCH_TK : FLUSH_BRANCH_NT;
            end
        end else if (u.opcode == INT_JALR) begin
            target = u.srcA + {{20{u.imm[11]}}, u.imm[11:0]};
            target[0] = 1'b0;
            e.flags = FLAGS_BRANCH;
            if (!u.predTaken || target[31:1] != u.predTarget[31:1]) begin
                e.flags = FLAGS_MISPRED;
                e.redir.valid = 1'b1;
                e.redir.dstPC = target;
                e.redir.cause = FLUSH_IBRANCH;
            end
        end else if (u.opcode == INT_JAL) begin
            e.flags = FLAGS_BRANCH;
        end
        return e;
    endfunction

    // outputs are sampled at the falling edge, half a cycle after they change
    task automatic observe();
        Expect e;
        if (issueCredit) begin
            issuerCredits++;
            if (issuerCredits > BUF_DEPTH)
                abortRun("issuer got back more credits than it spent");
        end
        if (resUop.valid) begin
            pendingReturn++;
            if (pendingReturn > RES_CREDITS)
                abortRun("a result was sent without a result credit");
            if (expected.size() == 0)
                abortRun("a result came out with no micro-op outstanding");
            if (expected[0].squashed)
                abortRun("a squashed micro-op produced a result");
            e = expected.pop_front();
            checkEq(resUop.result, e.result, "result");
            checkEq(resUop.tagDst, e.tagDst, "tagDst");
            checkEq(resUop.sqN, e.sqN, "sqN");
            checkEq(resUop.flags, e.flags, "flags");
            checkEq(redirect.valid, e.redir.valid, "redirect valid");
            if (e.redir.valid) begin
                checkEq(redirect.dstPC, e.redir.dstPC, "redirect target");
                checkEq(redirect.cause, e.redir.cause, "redirect cause");
                checkEq(redirect.sqN, e.redir.sqN, "redirect sqN");
                redirects++;
            end
            completed++;
        end else begin
            checkEq(redirect.valid, 1'b0, "redirect without a result");
        end
    endtask

    task automatic step(input logic doIssue);
        ExUop u;
        @(negedge clk);
        observe();
        inUop = '0;
        if (doIssue && issuerCredits > 0) begin
            u = randomUop(nextSqN);
            inUop = u;
            expected.push_back(predict(u));
            issuerCredits--;
            nextSqN++;
            issued++;
        end
        resCredit = 1'b0;
        if (holdCycles > 0)
            holdCycles--;
        else if (randBits(6) == 0)
            holdCycles = int'(randBits(6));  // long stretch of back-pressure
        else if (pendingReturn > 0 && randBits(1) != 0) begin
            resCredit = 1'b1;
            pendingReturn--;
        end
    endtask

    // held until the buffer is empty, so every younger entry is surely squashed
    task automatic runInvalidate();
        int k;
        int waitCycles;
        SqN diff;
        k = int'(randBits(4)) % expected.size();
        invalidateSqN = expected[k].sqN - SqN'(randBits(1));
        invalidate = 1'b1;
        foreach (expected[j]) begin
            diff = expected[j].sqN - invalidateSqN;
            if ($signed(diff) > 0)
                expected[j].squashed = 1'b1;
        end
        waitCycles = 0;
        while (issuerCredits != BUF_DEPTH) begin
            step(1'b0);
            waitCycles++;
            if (waitCycles > TIMEOUT_CYCLES)
                abortRun("timed out waiting for the buffer to drain during invalidate");
        end
        invalidate = 1'b0;
        while (expected.size() > 0 && expected[0].squashed) begin
            void'(expected.pop_front());
            squashedCount++;
        end
        checkEq(expected.size(), 0, "micro-ops left after invalidate");
    endtask

    task automatic drainAll();
        int waitCycles;
        waitCycles = 0;
        while (expected.size() > 0 || issuerCredits != BUF_DEPTH) begin
            step(1'b0);
            waitCycles++;
            if (waitCycles > TIMEOUT_CYCLES)
                abortRun("timed out waiting for outstanding micro-ops to complete");
        end
    endtask

    initial begin
        lfsr = 32'h1066_1c8d;
        rst = 1'b1;
        inUop = '0;
        invalidate = 1'b0;
        invalidateSqN = '0;
        resCredit = 1'b0;
        issuerCredits = BUF_DEPTH;
        pendingReturn = 0;
        holdCycles = 0;
        issued = 0;
        completed = 0;
        squashedCount = 0;
        redirects = 0;
        nextSqN = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (4) begin
            @(negedge clk);
            checkEq(issueCredit, 1'b0, "issueCredit after reset");
            checkEq(resUop.valid, 1'b0, "resUop valid after reset");
            checkEq(redirect.valid, 1'b0, "redirect valid after reset");
        end
        for (int i = 0; i < NUM_STEPS; i++) begin
            step(randBits(2) != 0);
            if (randBits(5) == 0 && expected.size() > 0)
                runInvalidate();
        end
        drainAll();
        $display("issued %0d, completed %0d, squashed %0d, redirects %0d",
                 issued, completed, squashedCount, redirects);
        $display("** PASS **");
        $finish;
    end

endmodule

/* uopBuffer.sv */
`timescale 1ns/1ps

module uopBuffer #(
    parameter int BUF_DEPTH = 4
) (
    input logic clk,
    input logic rst,
    input execPkg::ExUop inUop,
    input logic pop,
    output execPkg::ExUop headUop,
    output logic issueCredit
);
    import execPkg::*;

    localparam int PTR_BITS = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
    localparam int CNT_BITS = $clog2(BUF_DEPTH + 1);

    typedef logic [PTR_BITS-1:0] BufPtr;
    typedef logic [CNT_BITS-1:0] BufCount;

    ExUop entries [BUF_DEPTH];
    BufPtr rdPtr;
    BufPtr wrPtr;
    BufCount count;
    logic push;
    logic doPop;

    // wrap by compare so any depth works
    function automatic BufPtr nextPtr(input BufPtr ptr);
        return (ptr == BufPtr'(BUF_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push = inUop.valid;            // issuer only sends while it has a credit
    assign doPop = pop && (count != '0);

    always_ff @(posedge clk) begin
        if (push)
            entries[wrPtr] <= inUop;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
            issueCredit <= 1'b0;
        end else begin
            if (push)
                wrPtr <= nextPtr(wrPtr);
            if (doPop)
                rdPtr <= nextPtr(rdPtr);
            count <= count + BufCount'(push) - BufCount'(doPop);
            issueCredit <= doPop;  // one credit back per freed entry
        end
    end

    always_comb begin
        headUop = entries[rdPtr];
        headUop.valid = (count != '0);
    end

endmodule
